// ==== src/shapes_pkg.sv ====
// shared coordinate and colour types, point and triangle structs
// constant scene table of three coloured triangles in 160x90 space
`default_nettype none

package shapes_pkg;
    localparam int CORDW = 16;  // signed coordinate width
    localparam int CIDXW = 2;   // colour index width

    typedef logic signed [CORDW-1:0] coord_t;  // one screen coordinate
    typedef logic [CIDXW-1:0] cidx_t;          // palette index

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;  // vertex or pixel position

    typedef struct packed {
        point_t v0;
        point_t v1;
        point_t v2;
        cidx_t  cidx;  // fill colour
    } triangle_t;

    localparam int SHAPE_CNT = 3;

    // packs plain integers into one scene entry
    function automatic triangle_t make_tri(input int x0, y0, x1, y1, x2, y2, c);
        triangle_t t;
        t.v0 = '{x: coord_t'(x0), y: coord_t'(y0)};
        t.v1 = '{x: coord_t'(x1), y: coord_t'(y1)};
        t.v2 = '{x: coord_t'(x2), y: coord_t'(y2)};
        t.cidx = cidx_t'(c);
        return t;
    endfunction

    localparam triangle_t SCENE [SHAPE_CNT] = '{
        make_tri(30, 10, 140, 40, 80, 82, 3),  // large, spans most of screen
        make_tri(35, 80, 110, 45, 85, 5, 2),   // vertices in reverse y order
        make_tri(11, 18, 31, 75, 49, 48, 1)    // small one on the left
    };
endpackage

`default_nettype wire

// ==== src/draw_line.sv ====
// Bresenham line engine, all octants
// one point per enabled cycle, done pulse after the end point
`default_nettype none
`timescale 1ns/100ps

module draw_line import shapes_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   start,    // latch endpoints and begin
    input  wire logic   oe,       // step enable
    input  wire point_t p0,       // first point
    input  wire point_t p1,       // end point
    output point_t      pix,      // current point
    output logic        drawing,  // pix valid this cycle
    output logic        done      // single cycle, after end point
);
    typedef enum logic {IDLE, DRAW} line_state_t;

    line_state_t state;
    point_t p_end;                        // latched end point
    logic sx, sy;                         // step direction, 1 = increasing
    logic signed [CORDW:0] dx, dy;        // |dx| and -|dy|
    logic signed [CORDW:0] diff_x, diff_y;
    logic signed [CORDW:0] dx_init, dy_init;
    logic signed [CORDW+1:0] err, err_next;  // error term
    logic signed [CORDW+2:0] e2;          // doubled error
    logic step_x, step_y;

    // setup terms straight from the endpoint inputs
    always_comb begin
        diff_x = p1.x - p0.x;
        diff_y = p1.y - p0.y;
        dx_init = (diff_x < 0) ? -diff_x : diff_x;  // abs
        dy_init = (diff_y < 0) ? diff_y : -diff_y;  // negative abs
    end

    always_comb begin
        e2 = (CORDW+3)'(err) <<< 1;
        step_x = (e2 >= dy);  // move along x
        step_y = (e2 <= dx);  // move along y
        err_next = err;
        if (step_x) err_next = err_next + dy;
        if (step_y) err_next = err_next + dx;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            done <= 1'b0;
        end else begin
            done <= 1'b0;  // default low, pulse only
            case (state)
                IDLE: begin
                    if (start) begin
                        pix <= p0;
                        p_end <= p1;
                        sx <= (p1.x >= p0.x);
                        sy <= (p1.y >= p0.y);
                        dx <= dx_init;
                        dy <= dy_init;
                        err <= (CORDW+2)'(dx_init) + (CORDW+2)'(dy_init);
                        state <= DRAW;
                    end
                end
                default: begin  // DRAW
                    if (oe) begin
                        if (pix == p_end) begin  // end point emitted this cycle
                            done <= 1'b1;
                            state <= IDLE;
                        end else begin
                            if (step_x) pix.x <= sx ? coord_t'(pix.x + 1) : coord_t'(pix.x - 1);
                            if (step_y) pix.y <= sy ? coord_t'(pix.y + 1) : coord_t'(pix.y - 1);
                            err <= err_next;
                        end
                    end
                end
            endcase
        end
    end

    assign drawing = (state == DRAW) && oe;  // holds while oe low
endmodule

`default_nettype wire

// ==== src/draw_triangle_fill.sv ====
// filled triangle engine
// sorts vertices by y, walks long and short edges per row, emits spans
`default_nettype none
`timescale 1ns/100ps

module draw_triangle_fill import shapes_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      start,    // begin a triangle
    input  wire logic      oe,       // output enable, holds all stepping
    input  wire triangle_t tri_in,   // vertices, already scaled
    output point_t         pix,      // span pixel
    output logic           drawing,  // pix valid this cycle
    output logic           done      // single cycle after last span
);
    typedef enum logic [2:0] {
        IDLE, SORT, START_A, START_B, EDGE, SPAN, NEXT_B, FINISHED
    } fill_state_t;

    localparam coord_t X_MAX = coord_t'({1'b0, {(CORDW-1){1'b1}}});
    localparam coord_t X_MIN = coord_t'({1'b1, {(CORDW-1){1'b0}}});

    fill_state_t state;
    point_t va, vb, vc;            // top, middle, bottom after sort
    logic [1:0] sort_cnt;          // compare-swap step
    coord_t y_cur, x_cur;          // current row and span x
    coord_t x_left, x_right;       // span limits on this row
    coord_t lo, hi;                // limits incl. this cycle's edge points
    point_t pix_a, pix_b, b_p0, b_p1;
    logic drawing_a, drawing_b, done_a, done_b;
    logic start_a, start_b, en_a, en_b;
    logic a_busy, b_busy;          // edge line still running
    logic b_half;                  // short edge on second half
    logic a_on_row, b_on_row;      // edge still has points on y_cur

    assign b_p0 = b_half ? vb : va;  // top->mid, then mid->bottom
    assign b_p1 = b_half ? vc : vb;
    assign start_a = (state == START_A);
    assign start_b = (state == START_B) || (state == NEXT_B);

    always_comb begin
        a_on_row = a_busy && !done_a && (pix_a.y == y_cur);
        b_on_row = b_busy && !done_b && (pix_b.y == y_cur);
        en_a = (state == EDGE) && oe && a_on_row;  // one step at a time
        en_b = (state == EDGE) && oe && b_on_row;
        lo = x_left;
        hi = x_right;
        if (drawing_a && pix_a.x < lo) lo = pix_a.x;
        if (drawing_a && pix_a.x > hi) hi = pix_a.x;
        if (drawing_b && pix_b.x < lo) lo = pix_b.x;
        if (drawing_b && pix_b.x > hi) hi = pix_b.x;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            a_busy <= 1'b0;
            b_busy <= 1'b0;
            b_half <= 1'b0;
        end else begin
            if (done_a) a_busy <= 1'b0;
            if (done_b) b_busy <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        va <= tri_in.v0;
                        vb <= tri_in.v1;
                        vc <= tri_in.v2;
                        sort_cnt <= 2'd0;
                        state <= SORT;
                    end
                end
                SORT: begin  // three compare-swaps, one per cycle
                    sort_cnt <= sort_cnt + 2'd1;
                    case (sort_cnt)
                        2'd0: begin
                            if (va.y > vb.y) begin
                                va <= vb;
                                vb <= va;
                            end
                        end
                        2'd1: begin
                            if (vb.y > vc.y) begin
                                vb <= vc;
                                vc <= vb;
                            end
                        end
                        default: begin
                            if (va.y > vb.y) begin
                                va <= vb;
                                vb <= va;
                            end
                            state <= START_A;
                        end
                    endcase
                end
                START_A: begin  // long edge top to bottom
                    a_busy <= 1'b1;
                    b_half <= 1'b0;
                    y_cur <= va.y;
                    x_left <= X_MAX;
                    x_right <= X_MIN;
                    state <= START_B;
                end
                START_B, NEXT_B: begin
                    b_busy <= 1'b1;
                    state <= EDGE;
                end
                EDGE: begin
                    if (oe) begin
                        x_left <= lo;
                        x_right <= hi;
                        if (!a_on_row && !b_on_row) begin
                            if (!b_half && !(b_busy && !done_b)) begin  // reached middle
                                b_half <= 1'b1;
                                state <= NEXT_B;
                            end else begin
                                x_cur <= lo;
                                state <= SPAN;
                            end
                        end
                    end
                end
                SPAN: begin
                    if (oe) begin
                        if (x_cur == x_right) begin
                            if (y_cur == vc.y) begin  // bottom row done
                                state <= FINISHED;
                            end else begin
                                y_cur <= coord_t'(y_cur + 1);
                                x_left <= X_MAX;
                                x_right <= X_MIN;
                                state <= EDGE;
                            end
                        end else begin
                            x_cur <= coord_t'(x_cur + 1);
                        end
                    end
                end
                default: state <= IDLE;  // FINISHED
            endcase
        end
    end

    draw_line edge_a_i (
        .clk, .rst, .start(start_a), .oe(en_a), .p0(va), .p1(vc),
        .pix(pix_a), .drawing(drawing_a), .done(done_a)
    );

    draw_line edge_b_i (
        .clk, .rst, .start(start_b), .oe(en_b), .p0(b_p0), .p1(b_p1),
        .pix(pix_b), .drawing(drawing_b), .done(done_b)
    );

    assign pix = '{x: x_cur, y: y_cur};
    assign drawing = (state == SPAN) && oe;
    assign done = (state == FINISHED);
endmodule

`default_nettype wire

// ==== src/render_triangles_fill.sv ====
// scene sequencer, steps through the shape table
// scales each triangle and hands it to the fill engine
`default_nettype none
`timescale 1ns/100ps

module render_triangles_fill import shapes_pkg::*; #(
    parameter int SCALE = 1  // 1 = 160x90, 2 = 320x180, 4 = 640x360
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic oe,       // output enable
    input  wire logic start,    // start the scene
    output point_t    pix,      // pixel position
    output cidx_t     cidx,     // colour of current triangle
    output logic      drawing,  // pix valid this cycle
    output logic      done      // scene finished, held until rst
);
    typedef enum logic [1:0] {IDLE, LOAD, DRAW, FINISHED} seq_state_t;

    seq_state_t state;
    logic [$clog2(SHAPE_CNT)-1:0] shape_idx;  // current table entry
    triangle_t tri_cur;   // scaled triangle for the fill engine
    logic fill_start;     // single-cycle pulse
    logic fill_done;

    function automatic point_t scale_pt(input point_t p);
        return '{x: coord_t'(p.x * SCALE), y: coord_t'(p.y * SCALE)};
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            shape_idx <= '0;
            fill_start <= 1'b0;
        end else begin
            fill_start <= 1'b0;
            case (state)
                IDLE: begin
                    shape_idx <= '0;
                    if (start) state <= LOAD;
                end
                LOAD: begin  // fetch and scale the entry
                    tri_cur.v0 <= scale_pt(SCENE[shape_idx].v0);
                    tri_cur.v1 <= scale_pt(SCENE[shape_idx].v1);
                    tri_cur.v2 <= scale_pt(SCENE[shape_idx].v2);
                    tri_cur.cidx <= SCENE[shape_idx].cidx;
                    fill_start <= 1'b1;
                    state <= DRAW;
                end
                DRAW: begin
                    if (fill_done) begin
                        if (shape_idx == SHAPE_CNT - 1) begin
                            state <= FINISHED;
                        end else begin
                            shape_idx <= shape_idx + 1'b1;
                            state <= LOAD;
                        end
                    end
                end
                default: state <= FINISHED;  // stays until rst
            endcase
        end
    end

    draw_triangle_fill fill_i (
        .clk, .rst, .start(fill_start), .oe, .tri_in(tri_cur),
        .pix, .drawing, .done(fill_done)
    );

    assign cidx = tri_cur.cidx;  // registered colour of the loaded entry
    assign done = (state == FINISHED);
endmodule

`default_nettype wire

// ==== src/shapes_top.sv ====
// top level, connects the scene sequencer to the pixel port
`default_nettype none
`timescale 1ns/100ps

module shapes_top import shapes_pkg::*; #(
    parameter int SCALE = 1  // drawing scale factor
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic oe,       // output enable
    input  wire logic start,    // start pulse
    output point_t    pix,      // current pixel
    output cidx_t     cidx,     // pixel colour
    output logic      drawing,  // pixel valid
    output logic      done      // scene complete
);
    render_triangles_fill #(
        .SCALE(SCALE)
    ) render_i (
        .clk,
        .rst,
        .oe,
        .start,
        .pix,
        .cidx,
        .drawing,
        .done
    );
endmodule

`default_nettype wire

// ==== sim/shapes_properties.sv ====
// concurrent checks on the sequencer strobes and output enable
`default_nettype none
`timescale 1ns/100ps

module shapes_properties (
    input wire logic clk,
    input wire logic rst,
    input wire logic oe,
    input wire logic drawing,
    input wire logic done,
    input wire logic fill_start  // sequencer to fill engine
);
    // no pixel without output enable
    drawing_needs_oe: assert property (@(posedge clk) disable iff (rst) drawing |-> oe)
        else $error("drawing high while oe low");

    // scene done is a level, cleared only by rst
    done_held: assert property (@(posedge clk) disable iff (rst) done |=> done)
        else $error("done dropped without rst");

    fill_start_pulse: assert property (@(posedge clk) disable iff (rst)
        fill_start |=> !fill_start)
        else $error("fill start high for more than one cycle");
endmodule

`default_nettype wire

// ==== sim/shapes_tb.sv ====
// testbench for the triangle scene renderer
// reference geometry from the scene table, pixel checker, test sequence
`default_nettype none
`timescale 1ns/100ps

module shapes_tb import shapes_pkg::*; ();
    localparam int SCALE = 1;
    localparam bit [31:0] SEED = 32'hca4fe2a2;

    typedef struct packed {
        int x_lo;
        int x_hi;
        int y_lo;
        int y_hi;
    } box_t;  // bounding box of one triangle

    logic clk = 1'b0;
    logic rst;
    logic oe;
    logic start;
    point_t pix;
    cidx_t cidx;
    logic drawing;
    logic done;

    int fails [5] = '{default: 0};  // failed checks per test
    int colour_slot;                // test owning colour failures
    int geom_slot;                  // test owning geometry failures
    int tri_idx;                    // triangle the checker expects
    int late_pix;                   // pixels seen with done high
    int pix_cnt [SHAPE_CNT];
    int ref_cnt [SHAPE_CNT];        // counts of the oe-high run
    bit row_hit [SHAPE_CNT][1024];
    bit checking;
    int cycles;

    shapes_top #(.SCALE(SCALE)) shapes_top_i (
        .clk, .rst, .oe, .start, .pix, .cidx, .drawing, .done
    );

    bind render_triangles_fill shapes_properties props_i (
        .clk, .rst, .oe, .drawing, .done, .fill_start
    );

    always #4 clk = ~clk;  // 8 ns period

    // scaled vertex i of triangle k, axis 0 = x, 1 = y
    function automatic int vtx(input int k, input int i, input int axis);
        point_t p;
        p = (i == 0) ? SCENE[k].v0 : (i == 1) ? SCENE[k].v1 : SCENE[k].v2;
        return SCALE * ((axis == 0) ? int'(p.x) : int'(p.y));
    endfunction

    function automatic box_t bound_box(input int k);
        box_t b;
        b = '{x_lo: vtx(k, 0, 0), x_hi: vtx(k, 0, 0), y_lo: vtx(k, 0, 1), y_hi: vtx(k, 0, 1)};
        for (int i = 1; i < 3; i++) begin
            if (vtx(k, i, 0) < b.x_lo) b.x_lo = vtx(k, i, 0);
            if (vtx(k, i, 0) > b.x_hi) b.x_hi = vtx(k, i, 0);
            if (vtx(k, i, 1) < b.y_lo) b.y_lo = vtx(k, i, 1);
            if (vtx(k, i, 1) > b.y_hi) b.y_hi = vtx(k, i, 1);
        end
        return b;
    endfunction

    // edge function of edge i (vertex i to i+1) at (px, py)
    function automatic int edge_fn(input int k, input int i, input int px, input int py);
        int j;
        j = (i + 1) % 3;
        return (vtx(k, j, 0) - vtx(k, i, 0)) * (py - vtx(k, i, 1))
             - (vtx(k, j, 1) - vtx(k, i, 1)) * (px - vtx(k, i, 0));
    endfunction

    // inside test, one pixel of slack along x or y per edge
    function automatic bit inside_tol(input int k, input int px, input int py);
        int orient;
        int e;
        int ex;
        int ey;
        bit ok;
        orient = edge_fn(k, 0, vtx(k, 2, 0), vtx(k, 2, 1));
        ok = 1'b1;
        for (int i = 0; i < 3; i++) begin
            e = (orient < 0) ? -edge_fn(k, i, px, py) : edge_fn(k, i, px, py);
            ex = vtx(k, (i + 1) % 3, 0) - vtx(k, i, 0);
            ey = vtx(k, (i + 1) % 3, 1) - vtx(k, i, 1);
            ex = (ex < 0) ? -ex : ex;
            ey = (ey < 0) ? -ey : ey;
            if (e < -((ex > ey) ? ex : ey)) ok = 1'b0;  // |e|/max = axis distance
        end
        return ok;
    endfunction

    function automatic int scene_area();
        int a;
        int o;
        a = 0;
        for (int k = 0; k < SHAPE_CNT; k++) begin
            o = edge_fn(k, 0, vtx(k, 2, 0), vtx(k, 2, 1));
            a += ((o < 0) ? -o : o) / 2;  // o is twice the area
        end
        return a;
    endfunction

    task automatic check_pixel();
        box_t b;
        int px;
        int py;
        px = int'(pix.x);
        py = int'(pix.y);
        if (done) begin
            late_pix++;  // nothing may follow done
        end else begin
            if (cidx != SCENE[tri_idx].cidx && tri_idx < SHAPE_CNT - 1
                    && cidx == SCENE[tri_idx + 1].cidx) tri_idx++;  // next triangle
            assert (cidx == SCENE[tri_idx].cidx) else begin
                $display("Mismatch at %0t: cidx expected %0d, actual %0d",
                         $time, SCENE[tri_idx].cidx, cidx);
                fails[colour_slot]++;
            end
            b = bound_box(tri_idx);
            assert (px >= b.x_lo && px <= b.x_hi && py >= b.y_lo && py <= b.y_hi) else begin
                $display("pixel (%0d,%0d) at %0t is outside the bounding box of triangle %0d",
                         px, py, $time, tri_idx);
                fails[geom_slot]++;
            end
            assert (inside_tol(tri_idx, px, py)) else begin
                $display("pixel (%0d,%0d) at %0t is outside triangle %0d", px, py, $time, tri_idx);
                fails[geom_slot]++;
            end
            pix_cnt[tri_idx]++;
            if (py >= 0 && py < 1024) row_hit[tri_idx][py] = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        if (checking && drawing) check_pixel();
    end

    task automatic apply_reset();
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic run_scene(input bit random_oe);
        tri_idx = 0;
        late_pix = 0;
        for (int k = 0; k < SHAPE_CNT; k++) begin
            pix_cnt[k] = 0;
            for (int y = 0; y < 1024; y++) row_hit[k][y] = 1'b0;
        end
        checking = 1'b1;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done) begin
            oe = random_oe ? ($urandom % 2 == 1) : 1'b1;
            @(negedge clk);
        end
        oe = 1'b1;
    endtask

    // every colour reached, every row of each triangle covered
    task automatic check_scene_end();
        box_t b;
        int hit;
        assert (tri_idx == SHAPE_CNT - 1) else begin
            $display("colour sequence stopped at triangle %0d", tri_idx);
            fails[colour_slot]++;
        end
        for (int k = 0; k < SHAPE_CNT; k++) begin
            b = bound_box(k);
            hit = 0;
            for (int y = b.y_lo; y <= b.y_hi; y++) begin
                if (row_hit[k][y]) hit++;
            end
            assert (hit == b.y_hi - b.y_lo + 1) else begin
                $display("triangle %0d: %0d of %0d rows got a pixel", k, hit, b.y_hi - b.y_lo + 1);
                fails[geom_slot]++;
            end
        end
    endtask

    task automatic report(input int t, input string name);
        $display("test %0d %s: %s", t + 1, name, (fails[t] == 0) ? "pass" : "FAIL");
    endtask

    initial begin
        int limit;
        limit = 20 * scene_area();
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run not finished after %0d cycles", limit);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int total;
        int failed;
        void'($urandom(SEED));
        rst = 1'b1;
        oe = 1'b0;
        start = 1'b0;
        checking = 1'b0;
        colour_slot = 1;
        geom_slot = 2;
        apply_reset();

        oe = 1'b1;  // quiet outputs without start
        repeat (20) begin
            @(negedge clk);
            assert (!drawing) else begin
                $display("Mismatch at %0t: drawing expected 0, actual %0b", $time, drawing);
                fails[0]++;
            end
            assert (!done) else begin
                $display("Mismatch at %0t: done expected 0, actual %0b", $time, done);
                fails[0]++;
            end
        end
        report(0, "reset state");

        run_scene(1'b0);
        check_scene_end();
        report(1, "colour sequence");
        report(2, "geometry");

        repeat (20) begin
            @(negedge clk);
            assert (done) else begin
                $display("Mismatch at %0t: done expected 1, actual %0b", $time, done);
                fails[3]++;
            end
        end
        start = 1'b1;  // ignored once done
        @(negedge clk);
        start = 1'b0;
        repeat (50) @(negedge clk);
        assert (done) else begin
            $display("Mismatch at %0t: done expected 1, actual %0b", $time, done);
            fails[3]++;
        end
        assert (late_pix == 0) else begin
            $display("%0d pixels drawn after done", late_pix);
            fails[3]++;
        end
        report(3, "completion");
        ref_cnt = pix_cnt;

        checking = 1'b0;
        colour_slot = 4;
        geom_slot = 4;
        apply_reset();
        run_scene(1'b1);
        check_scene_end();
        for (int k = 0; k < SHAPE_CNT; k++) begin
            assert (pix_cnt[k] == ref_cnt[k]) else begin
                $display("Mismatch at %0t: pix_cnt[%0d] expected %0d, actual %0d",
                         $time, k, ref_cnt[k], pix_cnt[k]);
                fails[4]++;
            end
        end
        report(4, "back-pressure");

        total = 0;
        failed = 0;
        foreach (fails[t]) begin
            total += fails[t];
            if (fails[t] != 0) failed++;
        end
        $display("5 tests, %0d failed, %0d failed checks", failed, total);
        if (total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

// ==== all.f ====
src/shapes_pkg.sv
src/draw_line.sv
src/draw_triangle_fill.sv
src/render_triangles_fill.sv
src/shapes_top.sv
sim/shapes_properties.sv
sim/shapes_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= shapes_tb
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Some tests failed
PASS_MSG   ?= All tests passed
LINT_FLAGS ?= --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
